// ==== source/decodeStage_defines.svh ====
`ifndef DECODE_STAGE_DEFINES_SVH
`define DECODE_STAGE_DEFINES_SVH

// Datapath and address width
`define DATA_WIDTH 32

// Register file geometry
`define REG_ADDR_WIDTH 5
`define REG_COUNT 32

// Instruction field positions
`define OPCODE_MSB 31
`define OPCODE_LSB 26
`define RS_LSB 21
`define RT_LSB 16
`define RD_LSB 11
`define FUNCT_MSB 5
`define FUNCT_LSB 0

// Immediate and jump index widths
`define IMM_WIDTH 16
`define JUMP_INDEX_WIDTH 26

`endif

// ==== source/decodePkg.sv ====
`include "decodeStage_defines.svh"

package decodePkg;

    ////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////

    // Main opcodes in bits 31..26
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_ANDI  = 6'h0C,
        OP_ORI   = 6'h0D,
        OP_LUI   = 6'h0F,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } opcodeE;

    // R-type funct codes in bits 5..0
    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2A
    } functE;

    // ALU operation for the execute stage
    // Zero maps to add so a bubble is harmless
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4,
        ALU_LUI = 3'd5
    } aluOpE;

    // How the 16-bit immediate widens
    typedef enum logic [1:0] {
        IMM_SIGN  = 2'd0,
        IMM_ZERO  = 2'd1,
        IMM_UPPER = 2'd2
    } immKindE;

    ////////////////////////////////////////////////////////////
    // Control and pipeline bundles
    ////////////////////////////////////////////////////////////

    // Writeback stage controls
    typedef struct packed {
        logic regWrite;
        logic memToReg;
    } wbCtrlT;

    // Memory stage controls
    typedef struct packed {
        logic memRead;
        logic memWrite;
        logic branch;
    } memCtrlT;

    // Execute stage controls
    typedef struct packed {
        logic  regDst;
        logic  aluSrc;
        aluOpE aluOp;
    } exeCtrlT;

    // Full decoded word, all zero means bubble
    typedef struct packed {
        wbCtrlT  wb;
        memCtrlT mem;
        exeCtrlT exe;
        immKindE immKind;
    } ctrlWordT;

    // Whole ID/EX register
    typedef struct packed {
        ctrlWordT                           ctrl;
        logic [`DATA_WIDTH-1:0]             pc;
        logic [`DATA_WIDTH-1:0]             regA;
        logic [`DATA_WIDTH-1:0]             regB;
        logic [`DATA_WIDTH-1:0]             imm;
        logic [`REG_ADDR_WIDTH-1:0]         rs;
        logic [`REG_ADDR_WIDTH-1:0]         rt;
        logic [`REG_ADDR_WIDTH-1:0]         rd;
        logic [`OPCODE_MSB-`OPCODE_LSB:0]   opcode;
    } idExT;

endpackage

// ==== source/controlDecoder.sv ====
`include "decodeStage_defines.svh"

module controlDecoder
(
    input  logic [`DATA_WIDTH-1:0] instruction,
    output decodePkg::ctrlWordT    ctrlWord
);

    decodePkg::opcodeE opcode;
    decodePkg::functE  funct;
    decodePkg::aluOpE  rtypeOp;
    logic              rtypeKnown;

    // Raw fields viewed as encodings
    assign opcode = decodePkg::opcodeE'(instruction[`OPCODE_MSB:`OPCODE_LSB]);
    assign funct  = decodePkg::functE'(instruction[`FUNCT_MSB:`FUNCT_LSB]);

    ////////////////////////////////////////////////////////////
    // R-type funct table
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        rtypeKnown = 1'b1;
        case (funct)
            decodePkg::FN_ADD: rtypeOp = decodePkg::ALU_ADD;
            decodePkg::FN_SUB: rtypeOp = decodePkg::ALU_SUB;
            decodePkg::FN_AND: rtypeOp = decodePkg::ALU_AND;
            decodePkg::FN_OR:  rtypeOp = decodePkg::ALU_OR;
            decodePkg::FN_SLT: rtypeOp = decodePkg::ALU_SLT;
            default:
            begin
                // Unknown funct ends up as a no-op
                rtypeKnown = 1'b0;
                rtypeOp    = decodePkg::ALU_ADD;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Main opcode table
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        // Default is the all-zero no-op word
        ctrlWord = '0;
        case (opcode)
            decodePkg::OP_RTYPE:
            begin
                ctrlWord.wb.regWrite = rtypeKnown;
                ctrlWord.exe.regDst  = rtypeKnown;
                ctrlWord.exe.aluOp   = rtypeOp;
            end
            decodePkg::OP_ADDI:
            begin
                ctrlWord.wb.regWrite = 1'b1;
                ctrlWord.exe.aluSrc  = 1'b1;
                ctrlWord.exe.aluOp   = decodePkg::ALU_ADD;
                ctrlWord.immKind     = decodePkg::IMM_SIGN;
            end
            decodePkg::OP_ANDI:
            begin
                ctrlWord.wb.regWrite = 1'b1;
                ctrlWord.exe.aluSrc  = 1'b1;
                ctrlWord.exe.aluOp   = decodePkg::ALU_AND;
                ctrlWord.immKind     = decodePkg::IMM_ZERO;
            end
            decodePkg::OP_ORI:
            begin
                ctrlWord.wb.regWrite = 1'b1;
                ctrlWord.exe.aluSrc  = 1'b1;
                ctrlWord.exe.aluOp   = decodePkg::ALU_OR;
                ctrlWord.immKind     = decodePkg::IMM_ZERO;
            end
            decodePkg::OP_LUI:
            begin
                ctrlWord.wb.regWrite = 1'b1;
                ctrlWord.exe.aluSrc  = 1'b1;
                ctrlWord.exe.aluOp   = decodePkg::ALU_LUI;
                ctrlWord.immKind     = decodePkg::IMM_UPPER;
            end
            decodePkg::OP_LW:
            begin
                ctrlWord.wb.regWrite  = 1'b1;
                ctrlWord.wb.memToReg  = 1'b1;
                ctrlWord.mem.memRead  = 1'b1;
                ctrlWord.exe.aluSrc   = 1'b1;
                ctrlWord.exe.aluOp    = decodePkg::ALU_ADD;
            end
            decodePkg::OP_SW:
            begin
                ctrlWord.mem.memWrite = 1'b1;
                ctrlWord.exe.aluSrc   = 1'b1;
                ctrlWord.exe.aluOp    = decodePkg::ALU_ADD;
            end
            decodePkg::OP_BEQ:
            begin
                // Compare by subtraction further down the pipe
                ctrlWord.mem.branch = 1'b1;
                ctrlWord.exe.aluOp  = decodePkg::ALU_SUB;
            end
            // Jump resolves here, nothing travels down
            default:
            begin
                ctrlWord = '0;
            end
        endcase
    end

    // Memory stage never sees a read and a write together
    always_comb
    begin
        memExclusive: assert (!(ctrlWord.mem.memRead && ctrlWord.mem.memWrite));
    end

endmodule

// ==== source/registerFile.sv ====
`include "decodeStage_defines.svh"

module registerFile
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       writeEnable,
    input  logic [`REG_ADDR_WIDTH-1:0] writeReg,
    input  logic [`DATA_WIDTH-1:0]     writeData,
    input  logic [`REG_ADDR_WIDTH-1:0] readReg1,
    input  logic [`REG_ADDR_WIDTH-1:0] readReg2,
    input  logic                       debugOn,
    input  logic [`REG_ADDR_WIDTH-1:0] debugReadReg,
    output logic [`DATA_WIDTH-1:0]     readData1,
    output logic [`DATA_WIDTH-1:0]     readData2,
    output logic [`DATA_WIDTH-1:0]     debugData
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];
    logic                   writeLive;

    // Debug mode blocks writeback, register 0 never takes a write
    assign writeLive = writeEnable && !debugOn && (writeReg != '0);

    ////////////////////////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////////////////////////

    // One read path shared by all three ports
    function automatic logic [`DATA_WIDTH-1:0] readPort
    (
        input logic [`REG_ADDR_WIDTH-1:0] addr
    );
        logic [`DATA_WIDTH-1:0] value;
        if (addr == '0)
            value = '0;
        // Same-cycle write bypass
        else if (writeLive && (writeReg == addr))
            value = writeData;
        else
            value = regs[addr];
        return value;
    endfunction

    always_comb
    begin
        readData1 = readPort(readReg1);
        readData2 = readPort(readReg2);
        debugData = readPort(debugReadReg);
    end

    ////////////////////////////////////////////////////////////
    // Write port
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `REG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (writeLive)
        begin
            regs[writeReg] <= writeData;
        end
    end

    // Register 0 stays zero across any writeback traffic
    regZeroFixed: assert property (@(posedge clk) disable iff (rst)
        regs[0] == '0);

endmodule

// ==== source/idExLatch.sv ====
`include "decodeStage_defines.svh"

module idExLatch
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`DATA_WIDTH-1:0]     instruction,
    input  logic [`DATA_WIDTH-1:0]     pcIn,
    input  decodePkg::ctrlWordT        ctrlWord,
    input  logic [`DATA_WIDTH-1:0]     regA,
    input  logic [`DATA_WIDTH-1:0]     regB,
    input  logic                       exMemRead,
    input  logic [`REG_ADDR_WIDTH-1:0] exRd,
    input  logic                       flush,
    input  logic                       stopDebug,
    output decodePkg::idExT            idEx,
    output logic                       pcWrite,
    output logic                       ifIdWrite,
    output logic                       jumpTake,
    output logic [`DATA_WIDTH-1:0]     jumpTarget
);

    logic [`REG_ADDR_WIDTH-1:0]       rs;
    logic [`REG_ADDR_WIDTH-1:0]       rt;
    logic [`REG_ADDR_WIDTH-1:0]       rd;
    logic [`OPCODE_MSB-`OPCODE_LSB:0] opcode;
    logic [`IMM_WIDTH-1:0]            immField;
    logic [`DATA_WIDTH-1:0]           immValue;
    logic                             hazard;
    decodePkg::idExT                  nextIdEx;

    // Instruction fields
    assign opcode   = instruction[`OPCODE_MSB:`OPCODE_LSB];
    assign rs       = instruction[`RS_LSB +: `REG_ADDR_WIDTH];
    assign rt       = instruction[`RT_LSB +: `REG_ADDR_WIDTH];
    assign rd       = instruction[`RD_LSB +: `REG_ADDR_WIDTH];
    assign immField = instruction[`IMM_WIDTH-1:0];

    ////////////////////////////////////////////////////////////
    // Load-use hazard and jump
    ////////////////////////////////////////////////////////////

    // Load in EX writes a register this instruction reads
    assign hazard = exMemRead && (exRd != '0) && ((exRd == rs) || (exRd == rt));

    // Hold PC and IF/ID together for one cycle
    assign pcWrite   = !hazard;
    assign ifIdWrite = !hazard;

    assign jumpTake = (opcode == decodePkg::OP_J);

    // Pseudo-direct target, PC falls through otherwise
    assign jumpTarget = jumpTake ?
        {pcIn[`DATA_WIDTH-1:`JUMP_INDEX_WIDTH+2], instruction[`JUMP_INDEX_WIDTH-1:0], 2'b00} :
        pcIn;

    ////////////////////////////////////////////////////////////
    // Immediate
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        case (ctrlWord.immKind)
            decodePkg::IMM_ZERO:
                immValue = {{(`DATA_WIDTH-`IMM_WIDTH){1'b0}}, immField};
            decodePkg::IMM_UPPER:
                immValue = {immField, {(`DATA_WIDTH-`IMM_WIDTH){1'b0}}};
            default:
                immValue = {{(`DATA_WIDTH-`IMM_WIDTH){immField[`IMM_WIDTH-1]}}, immField};
        endcase
    end

    ////////////////////////////////////////////////////////////
    // ID/EX register
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        // Stall or flush turns control into a bubble
        nextIdEx.ctrl   = (hazard || flush) ? '0 : ctrlWord;
        // Payload latches regardless
        nextIdEx.pc     = pcIn;
        nextIdEx.regA   = regA;
        nextIdEx.regB   = regB;
        nextIdEx.imm    = immValue;
        nextIdEx.rs     = rs;
        nextIdEx.rt     = rt;
        nextIdEx.rd     = rd;
        nextIdEx.opcode = opcode;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            idEx <= '0;
        end
        // Debug stop freezes the register
        else if (!stopDebug)
        begin
            idEx <= nextIdEx;
        end
    end

    // A stalled cycle leaves a bubble behind it
    stallGivesBubble: assert property (@(posedge clk) disable iff (rst)
        (!pcWrite && !stopDebug) |=> (idEx.ctrl == '0));

    // Frozen while debug stop is up
    freezeHolds: assert property (@(posedge clk) disable iff (rst)
        stopDebug |=> $stable(idEx));

endmodule

// ==== source/decodeStage.sv ====
`include "decodeStage_defines.svh"

module decodeStage
(
    input  logic                       clk,
    input  logic                       rst,

    // From the IF/ID register
    input  logic [`DATA_WIDTH-1:0]     instruction,
    input  logic [`DATA_WIDTH-1:0]     pcIn,

    // Writeback port
    input  logic                       wbWrite,
    input  logic [`REG_ADDR_WIDTH-1:0] wbReg,
    input  logic [`DATA_WIDTH-1:0]     wbData,

    // Instruction in EX for the hazard check
    input  logic                       exMemRead,
    input  logic [`REG_ADDR_WIDTH-1:0] exRd,

    input  logic                       flush,

    // Debug access
    input  logic                       debugOn,
    input  logic [`REG_ADDR_WIDTH-1:0] debugReadReg,
    input  logic                       stopDebug,

    // Pipeline outputs
    output decodePkg::idExT            idEx,
    output logic                       pcWrite,
    output logic                       ifIdWrite,
    output logic                       jumpTake,
    output logic [`DATA_WIDTH-1:0]     jumpTarget,
    output logic [`DATA_WIDTH-1:0]     debugData
);

    decodePkg::ctrlWordT    ctrlWord;
    logic [`DATA_WIDTH-1:0] regA;
    logic [`DATA_WIDTH-1:0] regB;

    ////////////////////////////////////////////////////////////
    // Decoder and register file side by side
    ////////////////////////////////////////////////////////////

    controlDecoder i_controlDecoder
    (
        .instruction (instruction),
        .ctrlWord    (ctrlWord)
    );

    // Operand reads come straight from rs and rt
    registerFile i_registerFile
    (
        .clk          (clk),
        .rst          (rst),
        .writeEnable  (wbWrite),
        .writeReg     (wbReg),
        .writeData    (wbData),
        .readReg1     (instruction[`RS_LSB +: `REG_ADDR_WIDTH]),
        .readReg2     (instruction[`RT_LSB +: `REG_ADDR_WIDTH]),
        .debugOn      (debugOn),
        .debugReadReg (debugReadReg),
        .readData1    (regA),
        .readData2    (regB),
        .debugData    (debugData)
    );

    ////////////////////////////////////////////////////////////
    // Hazard check and pipeline register
    ////////////////////////////////////////////////////////////

    idExLatch i_idExLatch
    (
        .clk         (clk),
        .rst         (rst),
        .instruction (instruction),
        .pcIn        (pcIn),
        .ctrlWord    (ctrlWord),
        .regA        (regA),
        .regB        (regB),
        .exMemRead   (exMemRead),
        .exRd        (exRd),
        .flush       (flush),
        .stopDebug   (stopDebug),
        .idEx        (idEx),
        .pcWrite     (pcWrite),
        .ifIdWrite   (ifIdWrite),
        .jumpTake    (jumpTake),
        .jumpTarget  (jumpTarget)
    );

endmodule

// ==== sim/decodeStageTb.sv ====
`include "decodeStage_defines.svh"

module decodeStageTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_CYCLES    = 4000;
    localparam int RESET_TIMEOUT = 20;

    logic                       clk;
    logic                       rst;
    logic [`DATA_WIDTH-1:0]     instruction;
    logic [`DATA_WIDTH-1:0]     pcIn;
    logic                       wbWrite;
    logic [`REG_ADDR_WIDTH-1:0] wbReg;
    logic [`DATA_WIDTH-1:0]     wbData;
    logic                       exMemRead;
    logic [`REG_ADDR_WIDTH-1:0] exRd;
    logic                       flush;
    logic                       debugOn;
    logic [`REG_ADDR_WIDTH-1:0] debugReadReg;
    logic                       stopDebug;
    decodePkg::idExT            idEx;
    logic                       pcWrite;
    logic                       ifIdWrite;
    logic                       jumpTake;
    logic [`DATA_WIDTH-1:0]     jumpTarget;
    logic [`DATA_WIDTH-1:0]     debugData;

    // Reference model state
    logic [`DATA_WIDTH-1:0] shadowRegs [`REG_COUNT];
    decodePkg::idExT        expIdEx;
    decodePkg::idExT        expNext;
    logic                   expHazard;
    int                     stallCount;
    int                     freezeCount;

    // Supported opcodes and R-type funct codes
    logic [5:0] legalOps [9] = '{6'h00, 6'h02, 6'h04, 6'h08, 6'h0C, 6'h0D, 6'h0F, 6'h23, 6'h2B};
    logic [5:0] legalFuncts [5] = '{6'h20, 6'h22, 6'h24, 6'h25, 6'h2A};

    decodeStage i_dut
    (
        .clk          (clk),
        .rst          (rst),
        .instruction  (instruction),
        .pcIn         (pcIn),
        .wbWrite      (wbWrite),
        .wbReg        (wbReg),
        .wbData       (wbData),
        .exMemRead    (exMemRead),
        .exRd         (exRd),
        .flush        (flush),
        .debugOn      (debugOn),
        .debugReadReg (debugReadReg),
        .stopDebug    (stopDebug),
        .idEx         (idEx),
        .pcWrite      (pcWrite),
        .ifIdWrite    (ifIdWrite),
        .jumpTake     (jumpTake),
        .jumpTarget   (jumpTarget),
        .debugData    (debugData)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    // Control word straight from the MIPS decode table
    function automatic decodePkg::ctrlWordT expectedCtrl(input logic [`DATA_WIDTH-1:0] instr);
        decodePkg::ctrlWordT c;
        decodePkg::aluOpE    alu;
        logic                known;
        c     = '0;
        alu   = decodePkg::ALU_ADD;
        known = 1'b1;
        case (instr[`OPCODE_MSB:`OPCODE_LSB])
            6'h00:
            begin
                case (instr[5:0])
                    6'h20: alu = decodePkg::ALU_ADD;
                    6'h22: alu = decodePkg::ALU_SUB;
                    6'h24: alu = decodePkg::ALU_AND;
                    6'h25: alu = decodePkg::ALU_OR;
                    6'h2A: alu = decodePkg::ALU_SLT;
                    default: known = 1'b0;
                endcase
                // Unknown funct stays a no-op
                if (known)
                begin
                    c.wb.regWrite = 1'b1;
                    c.exe.regDst  = 1'b1;
                    c.exe.aluOp   = alu;
                end
            end
            6'h08:
            begin
                c.wb.regWrite = 1'b1;
                c.exe.aluSrc  = 1'b1;
                c.exe.aluOp   = decodePkg::ALU_ADD;
                c.immKind     = decodePkg::IMM_SIGN;
            end
            6'h0C, 6'h0D:
            begin
                c.wb.regWrite = 1'b1;
                c.exe.aluSrc  = 1'b1;
                c.exe.aluOp   = instr[26] ? decodePkg::ALU_OR : decodePkg::ALU_AND;
                c.immKind     = decodePkg::IMM_ZERO;
            end
            6'h0F:
            begin
                c.wb.regWrite = 1'b1;
                c.exe.aluSrc  = 1'b1;
                c.exe.aluOp   = decodePkg::ALU_LUI;
                c.immKind     = decodePkg::IMM_UPPER;
            end
            6'h23:
            begin
                c.wb.regWrite = 1'b1;
                c.wb.memToReg = 1'b1;
                c.mem.memRead = 1'b1;
                c.exe.aluSrc  = 1'b1;
            end
            6'h2B:
            begin
                c.mem.memWrite = 1'b1;
                c.exe.aluSrc   = 1'b1;
            end
            6'h04:
            begin
                c.mem.branch = 1'b1;
                c.exe.aluOp  = decodePkg::ALU_SUB;
            end
            // J and illegal opcodes send nothing down
            default: c = '0;
        endcase
        return c;
    endfunction

    // Sign form unless the opcode asks for zero or upper
    function automatic logic [`DATA_WIDTH-1:0] expectedImm(input logic [`DATA_WIDTH-1:0] instr);
        logic [`DATA_WIDTH-1:0] value;
        case (instr[`OPCODE_MSB:`OPCODE_LSB])
            6'h0C, 6'h0D: value = {16'h0000, instr[15:0]};
            6'h0F:        value = {instr[15:0], 16'h0000};
            default:      value = {{16{instr[15]}}, instr[15:0]};
        endcase
        return value;
    endfunction

    // Shadow read with same-cycle write-through
    function automatic logic [`DATA_WIDTH-1:0] readShadow(input logic [`REG_ADDR_WIDTH-1:0] addr);
        logic [`DATA_WIDTH-1:0] value;
        if (addr == '0)
            value = '0;
        else if (wbWrite && !debugOn && (wbReg == addr))
            value = wbData;
        else
            value = shadowRegs[addr];
        return value;
    endfunction

    task automatic checkValue(input string name, input logic [191:0] expected,
                              input logic [191:0] actual);
        assert (expected == actual)
        else
        begin
            $display("error %s: expected %0h, actual %0h", name, expected, actual);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic driveRandom();
        logic [`DATA_WIDTH-1:0] word;
        word = $urandom();
        // Mostly legal opcodes, a few illegal ones
        if ($urandom_range(99, 0) < 92)
            word[`OPCODE_MSB:`OPCODE_LSB] = legalOps[4'($urandom_range(8, 0))];
        if ((word[`OPCODE_MSB:`OPCODE_LSB] == 6'h00) && ($urandom_range(99, 0) < 85))
            word[5:0] = legalFuncts[3'($urandom_range(4, 0))];
        instruction = word;
        word = $urandom();
        pcIn = {word[31:2], 2'b00};
        // Writeback often aims at rs to hit the bypass
        wbWrite = ($urandom_range(99, 0) < 60);
        word    = $urandom();
        wbReg   = ($urandom_range(99, 0) < 30) ? instruction[`RS_LSB +: `REG_ADDR_WIDTH] : word[4:0];
        wbData  = $urandom();
        exMemRead = ($urandom_range(99, 0) < 30);
        word      = $urandom();
        case ($urandom_range(2, 0))
            0: exRd = instruction[`RS_LSB +: `REG_ADDR_WIDTH];
            1: exRd = instruction[`RT_LSB +: `REG_ADDR_WIDTH];
            default: exRd = word[4:0];
        endcase
        flush        = ($urandom_range(99, 0) < 10);
        debugOn      = ($urandom_range(99, 0) < 15);
        word         = $urandom();
        debugReadReg = word[4:0];
        stopDebug    = ($urandom_range(99, 0) < 12);
    endtask

    // Prediction and checks of the combinational outputs
    task automatic checkMidCycle();
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rt;
        logic                       take;
        rs        = instruction[`RS_LSB +: `REG_ADDR_WIDTH];
        rt        = instruction[`RT_LSB +: `REG_ADDR_WIDTH];
        expHazard = exMemRead && (exRd != '0) && ((exRd == rs) || (exRd == rt));
        take      = (instruction[`OPCODE_MSB:`OPCODE_LSB] == 6'h02);
        checkValue("pcWrite", 192'(!expHazard), 192'(pcWrite));
        checkValue("ifIdWrite", 192'(!expHazard), 192'(ifIdWrite));
        checkValue("jumpTake", 192'(take), 192'(jumpTake));
        checkValue("jumpTarget", 192'(take ? {pcIn[31:28], instruction[25:0], 2'b00} : pcIn),
                   192'(jumpTarget));
        checkValue("debugData", 192'(readShadow(debugReadReg)), 192'(debugData));
        // Bubble on stall or flush, payload latches anyway
        expNext.ctrl   = (expHazard || flush) ? '0 : expectedCtrl(instruction);
        expNext.pc     = pcIn;
        expNext.regA   = readShadow(rs);
        expNext.regB   = readShadow(rt);
        expNext.imm    = expectedImm(instruction);
        expNext.rs     = rs;
        expNext.rt     = rt;
        expNext.rd     = instruction[`RD_LSB +: `REG_ADDR_WIDTH];
        expNext.opcode = instruction[`OPCODE_MSB:`OPCODE_LSB];
        if (expHazard)
            stallCount++;
    endtask

    // Model update at the rising edge
    task automatic commitEdge();
        if (!stopDebug)
            expIdEx = expNext;
        else
            freezeCount++;
        if (wbWrite && !debugOn && (wbReg != '0))
            shadowRegs[wbReg] = wbData;
    endtask

    task automatic checkLatched();
        checkValue("idEx.ctrl", 192'(expIdEx.ctrl), 192'(idEx.ctrl));
        checkValue("idEx.regA", 192'(expIdEx.regA), 192'(idEx.regA));
        checkValue("idEx.regB", 192'(expIdEx.regB), 192'(idEx.regB));
        checkValue("idEx.imm", 192'(expIdEx.imm), 192'(idEx.imm));
        checkValue("idEx", 192'(expIdEx), 192'(idEx));
    endtask

    task automatic waitResetDone();
        int waited;
        waited = 0;
        while (!(pcWrite && ifIdWrite && (idEx == '0)))
        begin
            if (waited == RESET_TIMEOUT)
            begin
                $display("timeout: DUT outputs did not settle after reset release");
                $display("Done: errors found");
                $fatal(1);
            end
            else
            begin
                @(posedge clk);
                #1;
                waited++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial
    begin
        rst          = 1'b1;
        instruction  = '0;
        pcIn         = '0;
        wbWrite      = 1'b0;
        wbReg        = '0;
        wbData       = '0;
        exMemRead    = 1'b0;
        exRd         = '0;
        flush        = 1'b0;
        debugOn      = 1'b0;
        debugReadReg = '0;
        stopDebug    = 1'b0;
        expIdEx      = '0;
        expNext      = '0;
        expHazard    = 1'b0;
        stallCount   = 0;
        freezeCount  = 0;
        for (int i = 0; i < `REG_COUNT; i++)
            shadowRegs[i] = '0;
        void'($urandom(32'hc7f2b45a));

        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        waitResetDone();
        checkLatched();

        // Drive at +2 ns, check mid-cycle, commit and check after the edge
        for (int cycle = 0; cycle < NUM_CYCLES; cycle++)
        begin
            driveRandom();
            #8;
            checkMidCycle();
            @(posedge clk);
            commitEdge();
            #1;
            checkLatched();
            #1;
        end

        $display("Ran %0d cycles with %0d stalls and %0d frozen edges",
                 NUM_CYCLES, stallCount, freezeCount);
        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+source
source/decodePkg.sv
source/controlDecoder.sv
source/registerFile.sv
source/idExLatch.sv
source/decodeStage.sv
sim/decodeStageTb.sv

// ==== Makefile ====
# Verilator build and run of the decode stage testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
LINTFLAGS ?= --lint-only --timing --timescale 1ns/1ps
TOP       := decodeStageTb
FILELIST  := files.f
OBJDIR    := obj_dir
LOG       := run.log
PASS      := Done: no errors
SOURCES   := $(wildcard source/*.sv source/*.svh sim/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# Pass or fail comes from the log, not the exit status of the binary
run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
